//--- Makefile
# Verilator build and run for the GHRD fabric glue testbench

VERILATOR ?= verilator
TOP       ?= ghrd_fabric_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard rtl/*.sv) $(wildcard verification/*.sv) \
	$(wildcard include/*.svh) $(FILELIST)

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# exit status of the binary is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+include
rtl/ghrd_pkg.sv
rtl/key_debounce.sv
rtl/reset_pulse_gen.sv
rtl/hps_reset_ctrl.sv
rtl/ghrd_fabric_top.sv
verification/tb_clock_gen.sv
verification/ghrd_fabric_tb.sv

//--- include/ghrd_params.svh
/* GHRD fabric glue parameters
   widths, debounce time, sync depth and HPS reset pulse lengths */
`ifndef GHRD_PARAMS_SVH
`define GHRD_PARAMS_SVH

//============================================================
// board vector widths
//============================================================
`define GHRD_KEY_WIDTH        4      // push buttons, active low
`define GHRD_SW_WIDTH         10     // slide switches
`define GHRD_LED_WIDTH        9      // led lines from the processor pio
`define GHRD_STM_WIDTH        28     // hps trace event word

//============================================================
// timing
//============================================================
`define GHRD_SYNC_STAGES      2      // flops per async input
`define GHRD_DEBOUNCE_CYCLES  50000  // 1 ms at 50 MHz

// hps reset request pulse lengths in clocks
`define GHRD_COLD_PULSE       6
`define GHRD_WARM_PULSE       2
`define GHRD_DEBUG_PULSE      32

`endif

//--- rtl/ghrd_fabric_top.sv
/* GHRD fabric glue top level
   key debounce, HPS reset requests, trace event word and led pass-through */
`timescale 1ns/10ps
`include "ghrd_params.svh"

module ghrd_fabric_top #(
	parameter int debounce_cycles = `GHRD_DEBOUNCE_CYCLES  // key stable time in clocks
) (
	input  logic                  clock_50,
	input  logic                  arst_n,
	input  ghrd_pkg::key_t        key,               // push buttons, active low
	input  ghrd_pkg::sw_t         sw,                // slide switches
	input  ghrd_pkg::led_t        led_pio,           // led lines from the processor
	input  ghrd_pkg::reset_req_t  reset_req,         // cold/warm/debug request levels
	output ghrd_pkg::led_t        ledr,              // board leds
	output ghrd_pkg::stm_events_t stm_hw_events,     // to hps trace
	output logic                  cold_reset_req_n,
	output logic                  warm_reset_req_n,
	output logic                  debug_reset_req_n
);
	import ghrd_pkg::*;

	// zero pad above the switch field
	localparam int stm_pad = `GHRD_STM_WIDTH - `GHRD_SW_WIDTH - `GHRD_LED_WIDTH
		- `GHRD_KEY_WIDTH;
	localparam stm_events_t stm_rst = stm_events_t'({`GHRD_KEY_WIDTH{1'b1}});  // keys released

	key_t key_db;  // cleaned keys

	//============================================================
	// key debounce and hps reset requests
	//============================================================
	key_debounce #(.debounce_cycles(debounce_cycles)) key_debounce_inst (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.key      (key),
		.key_db   (key_db)
	);

	hps_reset_ctrl hps_reset_ctrl_inst (
		.clock_50          (clock_50),
		.arst_n            (arst_n),
		.reset_req         (reset_req),
		.cold_reset_req_n  (cold_reset_req_n),
		.warm_reset_req_n  (warm_reset_req_n),
		.debug_reset_req_n (debug_reset_req_n)
	);

	//============================================================
	// trace event word and leds
	//============================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			stm_hw_events <= stm_rst;
		end else begin
			stm_hw_events <= {{stm_pad{1'b0}}, sw, led_pio, key_db};  // keys in the low bits
		end
	end

	assign ledr = led_pio;  // straight to the board

endmodule

//--- rtl/ghrd_pkg.sv
/* GHRD fabric glue types
   shared vector types for keys, switches, leds, trace events and reset requests */
`include "ghrd_params.svh"

package ghrd_pkg;

	// board side vectors
	typedef logic [`GHRD_KEY_WIDTH-1:0] key_t;         // keys, 0 = pressed
	typedef logic [`GHRD_SW_WIDTH-1:0]  sw_t;          // switch levels
	typedef logic [`GHRD_LED_WIDTH-1:0] led_t;         // led drive, 1 = on

	// hps side vectors
	typedef logic [`GHRD_STM_WIDTH-1:0] stm_events_t;  // {pad, sw, led, key}

	// request levels into the hps reset block
	// bit 0 cold, bit 1 warm, bit 2 debug
	typedef logic [2:0] reset_req_t;

endpackage

//--- rtl/hps_reset_ctrl.sv
/* HPS reset request control
   synchronizes the cold, warm and debug request levels and turns each
   rising edge into its own fixed-length active-low request pulse */
`timescale 1ns/10ps
`include "ghrd_params.svh"

module hps_reset_ctrl (
	input  logic                 clock_50,
	input  logic                 arst_n,
	input  ghrd_pkg::reset_req_t reset_req,          // async levels, active high
	output logic                 cold_reset_req_n,
	output logic                 warm_reset_req_n,
	output logic                 debug_reset_req_n
);
	import ghrd_pkg::*;

	reset_req_t sync_q [`GHRD_SYNC_STAGES];  // request sync chain
	reset_req_t req_s;                       // synchronized requests

	assign req_s = sync_q[`GHRD_SYNC_STAGES-1];

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `GHRD_SYNC_STAGES; i++) begin
				sync_q[i] <= '0;                 // no request pending
			end
		end else begin
			sync_q[0] <= reset_req;
			for (int i = 1; i < `GHRD_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	reset_pulse_gen #(.pulse_cycles(`GHRD_COLD_PULSE)) cold_pulse_inst (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.req_sync    (req_s[0]),         // cold
		.reset_req_n (cold_reset_req_n)
	);

	reset_pulse_gen #(.pulse_cycles(`GHRD_WARM_PULSE)) warm_pulse_inst (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.req_sync    (req_s[1]),         // warm
		.reset_req_n (warm_reset_req_n)
	);

	reset_pulse_gen #(.pulse_cycles(`GHRD_DEBUG_PULSE)) debug_pulse_inst (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.req_sync    (req_s[2]),         // debug
		.reset_req_n (debug_reset_req_n)
	);

endmodule

//--- rtl/key_debounce.sv
/* key debounce
   per-key synchronizer followed by a stable-time counter, the cleaned
   key only follows the raw key once it has held for debounce_cycles */
`timescale 1ns/10ps
`include "ghrd_params.svh"

module key_debounce #(
	parameter int debounce_cycles = `GHRD_DEBOUNCE_CYCLES  // stable time in clocks, >= 1
) (
	input  logic           clock_50,
	input  logic           arst_n,
	input  ghrd_pkg::key_t key,     // raw keys from the board
	output ghrd_pkg::key_t key_db   // cleaned keys
);
	import ghrd_pkg::*;

	localparam int               cnt_w    = $clog2(debounce_cycles + 1);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

	key_t             sync_q [`GHRD_SYNC_STAGES];  // sync chain, [0] samples the pin
	key_t             key_s;                       // synchronized keys
	logic [cnt_w-1:0] cnt_q [`GHRD_KEY_WIDTH];     // stable-time counter per key

	assign key_s = sync_q[`GHRD_SYNC_STAGES-1];    // last sync stage

	//============================================================
	// input synchronizer
	//============================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `GHRD_SYNC_STAGES; i++) begin
				sync_q[i] <= '1;                       // released
			end
		end else begin
			sync_q[0] <= key;
			for (int i = 1; i < `GHRD_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];              // shift along the chain
			end
		end
	end

	//============================================================
	// stable-time counters
	//============================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			key_db <= '1;                              // all keys released
			for (int k = 0; k < `GHRD_KEY_WIDTH; k++) begin
				cnt_q[k] <= '0;
			end
		end else begin
			for (int k = 0; k < `GHRD_KEY_WIDTH; k++) begin
				if (key_s[k] == key_db[k]) begin
					cnt_q[k] <= '0;                    // agree, or glitch gone
				end else if (cnt_q[k] == cnt_last) begin
					cnt_q[k]  <= '0;
					key_db[k] <= key_s[k];             // held long enough, accept
				end else begin
					cnt_q[k] <= cnt_q[k] + cnt_w'(1);  // still settling
				end
			end
		end
	end

endmodule

//--- rtl/reset_pulse_gen.sv
/* reset pulse generator
   rising edge on a synchronized request starts a fixed-length active-low
   pulse, further edges are dropped until the pulse is over */
`timescale 1ns/10ps

module reset_pulse_gen #(
	parameter int pulse_cycles = 1  // low time in clocks, >= 1
) (
	input  logic clock_50,
	input  logic arst_n,
	input  logic req_sync,     // request level, already synchronized
	output logic reset_req_n   // low while the pulse runs
);

	localparam int               cnt_w    = $clog2(pulse_cycles + 1);
	localparam logic [cnt_w-1:0] cnt_load = cnt_w'(pulse_cycles);

	logic             req_prev_q;  // edge stage
	logic             req_rise;    // 0 -> 1 on the request
	logic [cnt_w-1:0] cnt_q;       // remaining low cycles

	assign req_rise = req_sync & ~req_prev_q;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			req_prev_q <= 1'b0;
			cnt_q      <= '0;            // idle, output high
		end else begin
			req_prev_q <= req_sync;
			if (cnt_q != '0) begin
				cnt_q <= cnt_q - cnt_w'(1);  // busy, edges ignored here
			end else if (req_rise) begin
				cnt_q <= cnt_load;           // start a new pulse
			end
		end
	end

	// counter is a register, so the pulse is glitch free
	assign reset_req_n = (cnt_q == '0);

endmodule

//--- verification/ghrd_fabric_tb.sv
/* GHRD fabric glue testbench
   random keys, switches, leds and reset requests checked against a cycle model */
`timescale 1ns/10ps
`include "ghrd_params.svh"

module ghrd_fabric_tb;
	import ghrd_pkg::*;

	localparam int db_cycles   = 16;                            // short debounce for sim
	localparam int accept_lat  = `GHRD_SYNC_STAGES + db_cycles + 1;  // key to event word
	localparam int req_lat     = `GHRD_SYNC_STAGES + 1;         // request edge to low output
	localparam int stm_pad     = `GHRD_STM_WIDTH - `GHRD_SW_WIDTH - `GHRD_LED_WIDTH
		- `GHRD_KEY_WIDTH;                                       // zero bits on top
	localparam int n_accept    = 12;
	localparam int n_glitch    = 12;
	localparam int n_event     = 200;
	localparam int n_retrig    = 6;
	localparam int n_steps     = n_accept + n_glitch + n_event + 3 + n_retrig + 2;
	localparam int max_step    = 64;                            // debug pulse window rounded up
	localparam int cycle_limit = n_steps * max_step;

	logic        clock_50;
	logic        arst_n;
	key_t        key;
	sw_t         sw;
	led_t        led_pio;
	reset_req_t  reset_req;
	led_t        ledr;
	stm_events_t stm_hw_events;
	logic        cold_reset_req_n;
	logic        warm_reset_req_n;
	logic        debug_reset_req_n;

	integer      seed      = 32'h254c_40c1;
	logic [31:0] rnd;
	int          errors    = 0;
	int          cycle_cnt = 0;
	int          pulse_len [3];

	// model state
	key_t        model_keys;   // expected key bits of the event word
	sw_t         model_sw;
	led_t        model_led;
	logic [2:0]  model_req_n;  // {debug, warm, cold}

	tb_clock_gen clock_gen_inst (
		.clock_50 (clock_50),
		.arst_n   (arst_n)
	);

	ghrd_fabric_top #(.debounce_cycles(db_cycles)) dut (
		.clock_50          (clock_50),
		.arst_n            (arst_n),
		.key               (key),
		.sw                (sw),
		.led_pio           (led_pio),
		.reset_req         (reset_req),
		.ledr              (ledr),
		.stm_hw_events     (stm_hw_events),
		.cold_reset_req_n  (cold_reset_req_n),
		.warm_reset_req_n  (warm_reset_req_n),
		.debug_reset_req_n (debug_reset_req_n)
	);

	//============================================================
	// failure handling and watchdog
	//============================================================
	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "run stopped on the first failure");
	endtask

	always @(posedge clock_50) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: test sequence still running after %0d cycles", cycle_limit);
			abort_run();
		end
	end

	//============================================================
	// checks against the model
	//============================================================
	task automatic check_outputs(string where);
		stm_events_t exp_stm;
		exp_stm = {{stm_pad{1'b0}}, model_sw, model_led, model_keys};
		assert (stm_hw_events == exp_stm) else begin
			errors++;
			$display("** Error %0t ns: %s, stm_hw_events %h expected %h",
				$time, where, stm_hw_events, exp_stm);
			abort_run();
		end
		assert ({debug_reset_req_n, warm_reset_req_n, cold_reset_req_n} == model_req_n) else begin
			errors++;
			$display("** Error %0t ns: %s, reset requests %b expected %b", $time, where,
				{debug_reset_req_n, warm_reset_req_n, cold_reset_req_n}, model_req_n);
			abort_run();
		end
	endtask

	// outputs are sampled on the falling edge, half a period after the update
	task automatic next_cycle(string where);
		@(negedge clock_50);
		check_outputs(where);
	endtask

	task automatic drive_sw_led(sw_t s, led_t l);
		sw        = s;
		led_pio   = l;
		#1;
		assert (ledr == l) else begin
			errors++;
			$display("** Error %0t ns: ledr %h expected %h", $time, ledr, l);
			abort_run();
		end
		check_outputs("event word before the clock edge");  // registered, old fields still out
		model_sw  = s;    // seen in the event word after the next edge
		model_led = l;
	endtask

	//============================================================
	// test steps
	//============================================================
	task automatic key_accept();
		key_t new_keys;
		rnd      = $random(seed);
		new_keys = model_keys ^ (rnd[3:0] | 4'b0001);  // at least one key moves
		key      = new_keys;
		for (int t = 1; t <= accept_lat; t++) begin
			if (t == accept_lat) begin
				model_keys = new_keys;                 // first cycle the new keys may show
			end
			next_cycle("key debounce acceptance");
		end
	endtask

	task automatic key_glitch();
		int glitch_len;
		rnd        = $random(seed);
		glitch_len = 1 + int'(rnd[7:4]) % (db_cycles - 1);  // 1 .. 15 cycles
		key        = model_keys ^ (rnd[3:0] | 4'b0001);
		repeat (glitch_len) next_cycle("key glitch");
		key = model_keys;                                   // bounce back
		repeat (accept_lat) next_cycle("key glitch recovery");
	endtask

	task automatic request_pulse(int idx);
		int window;
		window         = req_lat + `GHRD_DEBUG_PULSE + 8;
		reset_req[idx] = 1'b1;
		for (int t = 1; t <= window; t++) begin
			model_req_n[idx] = !(t >= req_lat && t < req_lat + pulse_len[idx]);
			next_cycle("reset request pulse");
		end
		reset_req[idx]   = 1'b0;
		model_req_n[idx] = 1'b1;
		repeat (4) next_cycle("reset request release");
	endtask

	task automatic debug_retrigger();
		int window;
		window       = req_lat + `GHRD_DEBUG_PULSE + 12;
		reset_req[2] = 1'b1;                             // this edge starts the pulse
		for (int t = 1; t <= window; t++) begin
			model_req_n[2] = !(t >= req_lat && t < req_lat + `GHRD_DEBUG_PULSE);
			next_cycle("debug request retrigger");
			if (t <= `GHRD_DEBUG_PULSE - req_lat - 1) begin
				rnd          = $random(seed);
				reset_req[2] = rnd[0];                   // edges land while busy
			end
		end
		reset_req[2]   = 1'b0;
		model_req_n[2] = 1'b1;
		repeat (4) next_cycle("debug request release");
	endtask

	//============================================================
	// main sequence
	//============================================================
	initial begin
		key          = '1;   // released
		sw           = '0;
		led_pio      = '0;
		reset_req    = '0;
		model_keys   = '1;
		model_sw     = '0;
		model_led    = '0;
		model_req_n  = 3'b111;
		pulse_len[0] = `GHRD_COLD_PULSE;
		pulse_len[1] = `GHRD_WARM_PULSE;
		pulse_len[2] = `GHRD_DEBUG_PULSE;

		next_cycle("values in reset");                   // arst_n still low here
		@(posedge arst_n);
		repeat (3) next_cycle("values after reset");

		repeat (n_accept) key_accept();
		repeat (n_glitch) key_glitch();

		for (int i = 0; i < n_event; i++) begin
			rnd = $random(seed);
			drive_sw_led(rnd[9:0], rnd[18:10]);
			next_cycle("event word");
		end

		for (int idx = 0; idx < 3; idx++) begin
			request_pulse(idx);                          // cold, warm, debug
		end
		repeat (n_retrig) debug_retrigger();

		if (errors == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- verification/tb_clock_gen.sv
/* testbench clock and reset
   8 ns clock, reset held low for the first three cycles */
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real period_ns  = 8.0,  // 125 MHz in sim time
	parameter int  rst_cycles = 3     // clocks with reset low
) (
	output logic clock_50,
	output logic arst_n
);

	initial begin
		clock_50 = 1'b0;
		forever #(period_ns / 2.0) clock_50 = ~clock_50;
	end

	initial begin
		arst_n = 1'b0;                    // reset from time 0
		repeat (rst_cycles) @(posedge clock_50);
		@(negedge clock_50);
		arst_n = 1'b1;                    // release away from the rising edge
	end

endmodule
